//--- verilog.f
logic/spi_bus_pkg.sv
logic/spi_mem_pkg.sv
logic/spi_pin_conditioner.sv
logic/spi_shift_reg.sv
logic/spi_txn_ctrl.sv
logic/spi_mem_regs.sv
logic/spi_data_mem.sv
logic/spi_memory.sv
tb/tb_spi_memory.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_spi_memory
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_spi_memory.sv
// Testbench for the SPI slave memory
// Mode 0 SPI master, shadow memory scoreboard and protocol assertions
`timescale 1ns/1ns

module tb_spi_memory;

    localparam int MAX_CYCLES = 64 * 300;    // 64 frames of about 281 clks each
    localparam int HALF_SCLK  = 8;           // clks per sclk half period

    logic       clk = 1'b0;
    logic       rst_n;
    logic       sclk_pin;
    logic       cs_pin;
    logic       mosi_pin;
    logic       wp_pin;
    wire        miso_pin;
    logic [7:0] leds;

    logic [31:0] lfsr = 32'hdf53;
    logic [7:0]  shadow [128];       // Expected memory contents
    bit          known  [128];       // Location written at least once
    logic [6:0]  pool   [32];        // Address set for the random phase
    logic [3:0]  cs_hist;            // Last four cs_pin samples
    int          errors = 0;
    int          frames = 0;
    int          cycles = 0;

    spi_memory u_dut (
        .clk(clk), .rst_n(rst_n), .sclk_pin(sclk_pin), .cs_pin(cs_pin),
        .mosi_pin(mosi_pin), .wp_pin(wp_pin), .miso_pin(miso_pin), .leds(leds)
    );

    always #10 clk = ~clk;           // 20 ns period

    // ------------------------------------------------------------------------
    // Random numbers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // Galois, right shift
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Concurrent checks
    // ------------------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_hist <= 4'hf;
        end else begin
            cs_hist <= {cs_hist[2:0], cs_pin};
        end
    end

    // cs settled high, so the miso driver must be off (enable low means Z)
    a_miso_off : assert property (@(posedge clk) disable iff (!rst_n)
        (&cs_hist) |-> !u_dut.miso_en)
        else begin
            errors++;
            $display("ERROR %0t miso_en got 1 expected 0", $time);
        end

    // Status only moves when a header byte is latched
    a_leds_idle : assert property (@(posedge clk) disable iff (!rst_n)
        (&cs_hist) |-> $stable(leds))
        else begin
            errors++;
            $display("ERROR %0t leds got 0x%02h expected 0x%02h", $time, leds, $past(leds));
        end

    // Mode 0 data holds while sclk is high
    a_miso_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (sclk_pin && $past(sclk_pin) && u_dut.miso_en && $past(u_dut.miso_en))
        |-> $stable(miso_pin))
        else begin
            errors++;
            $display("ERROR %0t miso_pin got %b expected %b", $time, miso_pin,
                     $past(miso_pin));
        end

    // ------------------------------------------------------------------------
    // SPI master
    // ------------------------------------------------------------------------
    // Sends nbits of tx MSB first; bits 9 to 16 of miso land in rx
    task automatic run_frame(input logic [15:0] tx, input int nbits, output logic [7:0] rx);
        rx = '0;
        @(posedge clk);
        cs_pin <= 1'b0;
        repeat (HALF_SCLK) @(posedge clk);
        for (int i = 0; i < nbits; i++) begin
            mosi_pin <= tx[15-i];                   // Low phase starts
            repeat (HALF_SCLK - 1) @(posedge clk);
            @(negedge clk);
            if (i >= 8) begin
                rx = {rx[6:0], miso_pin};           // Sampled just before the rise
            end
            @(posedge clk);
            sclk_pin <= 1'b1;
            repeat (HALF_SCLK) @(posedge clk);
            sclk_pin <= 1'b0;
        end
        repeat (HALF_SCLK) @(posedge clk);
        cs_pin <= 1'b1;
        repeat (HALF_SCLK) @(posedge clk);         // Idle gap between frames
        frames++;
    endtask

    task automatic check_leds(input logic [6:0] addr, input logic rd);
        assert (leds == {rd, addr}) else begin
            errors++;
            $display("ERROR %0t leds got 0x%02h expected 0x%02h", $time, leds, {rd, addr});
        end
    endtask

    task automatic write_mem(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] rx;
        run_frame({addr, 1'b0, data}, 16, rx);
        if (!wp_pin) begin                          // Protected writes are dropped
            shadow[addr] = data;
            known[addr]  = 1'b1;
        end
        check_leds(addr, 1'b0);
    endtask

    task automatic read_mem(input logic [6:0] addr);
        logic [7:0] rx;
        run_frame({addr, 1'b1, 8'h00}, 16, rx);
        assert (rx == shadow[addr]) else begin
            errors++;
            $display("ERROR %0t miso_pin byte at 0x%02h got 0x%02h expected 0x%02h",
                     $time, addr, rx, shadow[addr]);
        end
        check_leds(addr, 1'b1);
    endtask

    // ------------------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------------------
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d clk cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [6:0] first_addr;
        logic [6:0] addr;
        logic [7:0] rx;
        int         reads;
        rst_n    = 1'b0;
        sclk_pin = 1'b0;
        cs_pin   = 1'b1;
        mosi_pin = 1'b0;
        wp_pin   = 1'b0;
        reads    = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Reset state
        assert (!u_dut.miso_en) else begin
            errors++;
            $display("ERROR %0t miso_en got 1 expected 0", $time);
        end
        check_leds(7'h00, 1'b0);

        // Write then read back one byte
        first_addr = 7'(random_bits(7));
        write_mem(first_addr, 8'(random_bits(8)));
        read_mem(first_addr);

        // Random mix over a 32-address pool
        for (int i = 0; i < 32; i++) begin
            pool[i] = 7'(random_bits(7));
        end
        for (int i = 0; i < 32; i++) begin
            addr = pool[5'(random_bits(5))];
            if (random_bits(1) == 32'd1 && known[addr]) begin
                read_mem(addr);
            end else begin
                write_mem(addr, 8'(random_bits(8)));
            end
        end

        // Write protect keeps the old byte
        wp_pin <= 1'b1;
        repeat (8) @(posedge clk);                  // Strap through its synchronizer
        write_mem(first_addr, ~shadow[first_addr]);
        read_mem(first_addr);
        write_mem(first_addr, 8'(random_bits(8)));
        read_mem(first_addr);
        wp_pin <= 1'b0;
        repeat (8) @(posedge clk);

        // cs high in the data byte aborts the write
        run_frame({first_addr, 1'b0, ~shadow[first_addr]}, 12, rx);
        check_leds(first_addr, 1'b0);               // Header was already latched
        read_mem(first_addr);
        addr = 7'(random_bits(7));
        write_mem(addr, 8'(random_bits(8)));
        read_mem(addr);

        // Sweep over what the pool holds
        for (int i = 0; i < 32; i++) begin
            if (known[pool[i]] && reads < 16) begin
                read_mem(pool[i]);
                reads++;
            end
        end

        repeat (10) @(posedge clk);
        $display("Run complete: %0d frames, %0d errors", frames, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- logic/spi_memory.sv
// SPI slave memory, top level
// Mode 0 SPI access to a 128-byte memory with write protect and status leds
`timescale 1ns/1ns

module spi_memory
    import spi_bus_pkg::*;
    import spi_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sclk_pin,
    input  logic       cs_pin,
    input  logic       mosi_pin,
    input  logic       wp_pin,
    output wire        miso_pin,     // Tri-state
    output logic [7:0] leds
);

    spi_pin_t              sclk_c;
    spi_pin_t              cs_c;
    spi_pin_t              mosi_c;
    logic                  shift_en;
    logic                  load;
    logic                  rd_strobe;
    logic                  miso_en;
    logic                  wp;
    logic                  miso_q;      // Falling-edge miso flop
    logic [MEM_DATA_W-1:0] q;
    logic [MEM_DATA_W-1:0] rdata;
    mem_cmd_t              mem_cmd;

    // --------------------------------------------------------------------------
    // Pin conditioning
    // --------------------------------------------------------------------------
    spi_pin_conditioner #(.INIT(1'b0)) u_sclk_cond (
        .clk(clk), .rst_n(rst_n), .pin(sclk_pin), .cond(sclk_c)
    );
    spi_pin_conditioner #(.INIT(1'b1)) u_cs_cond (    // cs idles high
        .clk(clk), .rst_n(rst_n), .pin(cs_pin), .cond(cs_c)
    );
    spi_pin_conditioner #(.INIT(1'b0)) u_mosi_cond (
        .clk(clk), .rst_n(rst_n), .pin(mosi_pin), .cond(mosi_c)
    );

    // --------------------------------------------------------------------------
    // Datapath and control
    // --------------------------------------------------------------------------
    spi_shift_reg u_shift_reg (
        .clk(clk), .rst_n(rst_n), .shift_en(shift_en), .sin(mosi_c.level),
        .load(load), .pdata(rdata), .q(q)
    );

    spi_txn_ctrl u_txn_ctrl (
        .clk(clk), .rst_n(rst_n), .sclk(sclk_c), .cs(cs_c), .q(q), .wp(wp),
        .shift_en(shift_en), .load(load), .rd_strobe(rd_strobe),
        .mem_cmd(mem_cmd), .miso_en(miso_en)
    );

    spi_mem_regs u_mem_regs (
        .clk(clk), .rst_n(rst_n), .wp_pin(wp_pin), .mem_cmd(mem_cmd),
        .wp(wp), .leds(leds)
    );

    spi_data_mem u_data_mem (
        .clk(clk), .mem_cmd(mem_cmd), .rd_strobe(rd_strobe), .rdata(rdata)
    );

    // --------------------------------------------------------------------------
    // miso driver
    // --------------------------------------------------------------------------
    // New bit on sclk fall, master samples on the next rise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miso_q <= 1'b0;
        end else if (sclk_c.fall) begin
            miso_q <= q[MEM_DATA_W-1];
        end
    end

    assign miso_pin = miso_en ? miso_q : 1'bz;     // Off the bus unless reading

endmodule

//--- logic/spi_data_mem.sv
// SPI data memory
// 128 x 8 array with a clocked write port and a registered read
`timescale 1ns/1ns

module spi_data_mem
    import spi_mem_pkg::*;
(
    input  logic                  clk,
    input  mem_cmd_t              mem_cmd,
    input  logic                  rd_strobe,    // Read at this edge
    output logic [MEM_DATA_W-1:0] rdata
);

    logic [MEM_DATA_W-1:0] mem [MEM_DEPTH];

    // --------------------------------------------------------------------------
    // Array
    // --------------------------------------------------------------------------
    // Write and read strobes fall in different frames
    always_ff @(posedge clk) begin
        if (mem_cmd.we) begin
            mem[mem_cmd.addr] <= mem_cmd.wdata;
        end
        if (rd_strobe) begin
            rdata <= mem[mem_cmd.addr];     // Held until next read
        end
    end

endmodule

//--- logic/spi_mem_regs.sv
// SPI memory register block
// Write-protect strap and the leds status register
`timescale 1ns/1ns

module spi_mem_regs
    import spi_bus_pkg::*;
    import spi_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wp_pin,        // Pin-strapped write protect
    input  mem_cmd_t mem_cmd,
    output logic     wp,
    output logic [7:0] leds         // {rd, addr}
);

    logic [SPI_SYNC_STAGES-1:0] wp_sync;    // Same depth as the SPI pins

    // --------------------------------------------------------------------------
    // Write protect
    // --------------------------------------------------------------------------
    // Strap only moves while cs is high
    // The controller looks at wp once per frame, at commit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wp_sync <= '0;
            wp      <= 1'b0;
        end else begin
            wp_sync <= {wp_sync[SPI_SYNC_STAGES-2:0], wp_pin};
            wp      <= wp_sync[SPI_SYNC_STAGES-1];
        end
    end

    // --------------------------------------------------------------------------
    // Status
    // --------------------------------------------------------------------------
    // Address and rd in mem_cmd only move when a header is latched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else begin
            leds <= {mem_cmd.rd, mem_cmd.addr};    // Flag in bit 7
        end
    end

endmodule

//--- logic/spi_txn_ctrl.sv
// SPI transaction controller
// Counts frame bits, splits off address and rd flag, strobes the memory
`timescale 1ns/1ns

module spi_txn_ctrl
    import spi_bus_pkg::*;
    import spi_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_pin_t              sclk,
    input  spi_pin_t              cs,
    input  logic [MEM_DATA_W-1:0] q,            // Shift register contents
    input  logic                  wp,           // Write protect
    output logic                  shift_en,
    output logic                  load,
    output logic                  rd_strobe,
    output mem_cmd_t              mem_cmd,
    output logic                  miso_en
);

    txn_state_e state;
    txn_state_e state_nxt;

    logic [SPI_CNT_W-1:0]  bit_cnt;     // sclk bits taken this frame
    logic [MEM_ADDR_W-1:0] addr_q;      // Latched address
    logic                  rd_q;        // Latched rd flag
    logic                  shifting;    // State takes sclk bits
    logic                  hdr_done;    // Header byte sits in q
    logic                  last_bit;    // Final sclk bit of the frame

    // --------------------------------------------------------------------------
    // Bit tracking
    // --------------------------------------------------------------------------
    assign shifting = (state == GET_ADDR) || (state == READ_SHIFT) ||
                      (state == WRITE_SHIFT);
    assign shift_en = shifting && sclk.rise && !cs.level;

    // One clk after the eighth shift
    assign hdr_done = (state == GET_ADDR) && (bit_cnt == SPI_CNT_W'(SPI_HDR_BITS));
    assign last_bit = shift_en && (bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS - 1));

    // --------------------------------------------------------------------------
    // Next state
    // --------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cs.fall) begin
                    state_nxt = GET_ADDR;           // Frame start
                end
            end
            GET_ADDR: begin
                if (hdr_done) begin
                    state_nxt = q[0] ? READ_LOAD : WRITE_SHIFT;
                end
            end
            READ_LOAD:    state_nxt = READ_SHIFT;    // rdata loads this cycle
            READ_SHIFT: begin
                if (last_bit) begin
                    state_nxt = DONE;
                end
            end
            WRITE_SHIFT: begin
                if (last_bit) begin
                    state_nxt = WRITE_COMMIT;
                end
            end
            WRITE_COMMIT: state_nxt = DONE;
            DONE:         state_nxt = DONE;          // Extra sclk ignored
            default:      state_nxt = IDLE;
        endcase
        // cs high ends the frame wherever it is
        if (cs.rise) begin
            state_nxt = IDLE;
        end
    end

    // --------------------------------------------------------------------------
    // Registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
            addr_q  <= '0;
            rd_q    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE) begin
                bit_cnt <= '0;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // Address in q[7:1], rd flag in q[0]
            if (hdr_done) begin
                addr_q <= q[MEM_DATA_W-1:1];
                rd_q   <= q[0];
            end
        end
    end

    // --------------------------------------------------------------------------
    // Outputs
    // --------------------------------------------------------------------------
    assign rd_strobe = hdr_done && q[0];            // rdata valid next clk
    assign load      = (state == READ_LOAD);        // 2 clks after 8th rise
    assign miso_en   = (state == READ_SHIFT) && !cs.level;

    // Header cycle forwards q so the read can start at once
    always_comb begin
        mem_cmd.addr  = hdr_done ? q[MEM_DATA_W-1:1] : addr_q;
        mem_cmd.rd    = hdr_done ? q[0] : rd_q;
        mem_cmd.wdata = q;                          // Full byte by commit
        mem_cmd.we    = (state == WRITE_COMMIT) && !wp;
    end

endmodule

//--- logic/spi_shift_reg.sv
// SPI shift register
// MSB-first serial in and out with a parallel load for read data
`timescale 1ns/1ns

module spi_shift_reg
    import spi_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  shift_en,     // One clk per sclk rise
    input  logic                  sin,          // Conditioned mosi level
    input  logic                  load,         // Parallel load strobe
    input  logic [MEM_DATA_W-1:0] pdata,        // Memory read data
    output logic [MEM_DATA_W-1:0] q
);

    // --------------------------------------------------------------------------
    // Next value
    // --------------------------------------------------------------------------
    logic [MEM_DATA_W-1:0] shifted;

    // Shift left so the first bit received ends up in the MSB
    assign shifted = {q[MEM_DATA_W-2:0], sin};

    // --------------------------------------------------------------------------
    // Register
    // --------------------------------------------------------------------------
    // Load wins over shift
    // Both are single-cycle strobes and never meet in a legal frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (load) begin
            q <= pdata;                 // Read byte for miso
        end else if (shift_en) begin
            q <= shifted;               // Sample mosi
        end
    end

    // q[MEM_DATA_W-1] is the serial out
    // The miso flop at the top level takes it on sclk fall

endmodule

//--- logic/spi_pin_conditioner.sv
// SPI pin conditioner
// Brings one SPI pin into the clk domain and flags its edges
`timescale 1ns/1ns

module spi_pin_conditioner
    import spi_bus_pkg::*;
#(
    parameter logic INIT = 1'b0     // Idle level of the pin
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pin,
    output spi_pin_t cond
);

    logic [SPI_SYNC_STAGES-1:0] sync_q;     // Bit 0 nearest the pin
    logic                       stable;     // Last synchronizer stage

    assign stable = sync_q[SPI_SYNC_STAGES-1];

    // Synchronizer chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= {SPI_SYNC_STAGES{INIT}};
        end else begin
            sync_q <= {sync_q[SPI_SYNC_STAGES-2:0], pin};
        end
    end

    // cond.level doubles as the history flop
    // Strobes land SPI_SYNC_STAGES+1 clks after the pin moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cond <= '{level: INIT, rise: 1'b0, fall: 1'b0};
        end else begin
            cond.level <= stable;
            cond.rise  <= stable & ~cond.level;     // New high
            cond.fall  <= ~stable & cond.level;     // New low
        end
    end

endmodule

//--- logic/spi_mem_pkg.sv
// SPI memory package
// Array geometry, transaction FSM states and the memory command bundle
package spi_mem_pkg;

    // --------------------------------------------------------------------------
    // Geometry
    // --------------------------------------------------------------------------
    localparam int MEM_ADDR_W = 7;      // Byte address
    localparam int MEM_DATA_W = 8;      // One byte per location
    localparam int MEM_DEPTH  = 128;

    // --------------------------------------------------------------------------
    // Transaction FSM
    // --------------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,           // cs high, waiting for frame start
        GET_ADDR,       // Shifting in address and rd flag
        READ_LOAD,      // Memory byte into shift register
        READ_SHIFT,     // Byte going out on miso
        WRITE_SHIFT,    // Data byte coming in on mosi
        WRITE_COMMIT,   // One-cycle write strobe
        DONE            // Frame complete, wait for cs high
    } txn_state_e;

    // Command from the controller to memory and status registers
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic                  rd;      // 1 = read
        logic [MEM_DATA_W-1:0] wdata;
        logic                  we;      // Single-cycle write strobe
    } mem_cmd_t;

endpackage

//--- logic/spi_bus_pkg.sv
// SPI bus package
// Frame length, synchronizer depth and the conditioned pin bundle
package spi_bus_pkg;

    // --------------------------------------------------------------------------
    // Framing
    // --------------------------------------------------------------------------
    localparam int SPI_FRAME_BITS = 16;                    // Address byte + data byte
    localparam int SPI_HDR_BITS   = SPI_FRAME_BITS / 2;    // Header byte done here
    localparam int SPI_CNT_W      = $clog2(SPI_FRAME_BITS + 1);

    // Metastability flops per input pin
    localparam int SPI_SYNC_STAGES = 2;

    // --------------------------------------------------------------------------
    // Conditioned pin
    // --------------------------------------------------------------------------
    // Level after the synchronizer plus one-clk edge strobes
    typedef struct packed {
        logic level;    // Synchronized pin value
        logic rise;     // 0 -> 1 seen
        logic fall;     // 1 -> 0 seen
    } spi_pin_t;

endpackage
